//--- verilog/lsu_pkg.sv
// shared types and constants of the load/store unit, imported by every lsu module
`default_nettype none

package lsu_pkg;

  ////////////////////
  // widths and depth

  localparam int xlen_lp   = 32;  // data and address width
  localparam int nbytes_lp = 4;   // byte lanes per bus word
  localparam int depth_lp  = 2;   // max outstanding bus transactions

  typedef logic [1:0] cnt_t;  // outstanding count, holds 0..depth_lp

  ////////////////////
  // encodings

  // access size as delivered by the ex stage
  typedef enum logic [1:0] {
    dt_word     = 2'b00,
    dt_half     = 2'b01,
    dt_byte     = 2'b10,
    dt_byte_alt = 2'b11  // second byte code, same behavior
  } data_type_e;

  // fill of the upper bits on loads
  typedef enum logic [1:0] {
    se_zero = 2'b00,
    se_sign = 2'b01,
    se_ones = 2'b10
  } sign_ext_e;

  ////////////////////
  // bundles

  // one load/store request from ex
  typedef struct packed {
    logic               we;          // 1 = store
    data_type_e         dtype;
    sign_ext_e          sign_ext;
    logic [1:0]         reg_offset;  // byte offset of store data inside the register
    logic               useincr;     // address = a + b when set, else a
    logic [xlen_lp-1:0] operand_a;
    logic [xlen_lp-1:0] operand_b;
    logic [xlen_lp-1:0] wdata;
  } lsu_req_t;

  // obi address phase
  typedef struct packed {
    logic [xlen_lp-1:0]   addr;
    logic                 we;
    logic [nbytes_lp-1:0] be;
    logic [xlen_lp-1:0]   wdata;
  } obi_req_t;

  // what wb needs to shape the returning load word
  typedef struct packed {
    data_type_e dtype;
    logic [1:0] offset;  // low address bits of the access
    sign_ext_e  sign_ext;
    logic       we;
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/lsu_req_gen.sv
// lsu input side: forms address, byte enables and lane-rotated store data from an ex request
`default_nettype none

module lsu_req_gen (
  input  lsu_pkg::lsu_req_t lsu_req_i,         // request held stable by ex
  input  logic              data_req_ex_i,     // ex wants an access
  output lsu_pkg::obi_req_t obi_req_o,         // address phase towards the bus
  output lsu_pkg::wb_ctrl_t wb_ctrl_o,         // control for the wb side
  output logic              data_misaligned_o  // access crosses a word boundary
);

  import lsu_pkg::*;

  logic [xlen_lp-1:0]   addr;       // effective address
  logic [1:0]           off;        // byte offset inside the word
  logic [1:0]           wdata_off;  // store rotate amount in bytes
  logic [nbytes_lp-1:0] be;
  logic [xlen_lp-1:0]   wdata;      // store data placed in its lanes

  ////////////////////
  // address

  assign addr = lsu_req_i.useincr ? (lsu_req_i.operand_a + lsu_req_i.operand_b)
                                  : lsu_req_i.operand_a;
  assign off  = addr[1:0];

  ////////////////////
  // byte enables

  // only the first part of a misaligned access is issued
  always_comb begin
    unique case (lsu_req_i.dtype)
      dt_word: be = 4'b1111 << off;  // lanes off..3
      dt_half: begin
        if (off == 2'd3) be = 4'b1000;  // upper byte falls into next word
        else             be = 4'b0011 << off;
      end
      dt_byte, dt_byte_alt: be = 4'b0001 << off;
    endcase
  end

  ////////////////////
  // store data

  assign wdata_off = off - lsu_req_i.reg_offset;  // wraps mod 4

  always_comb begin
    unique case (wdata_off)  // rotate left in whole bytes
      2'd0: wdata = lsu_req_i.wdata;
      2'd1: wdata = {lsu_req_i.wdata[23:0], lsu_req_i.wdata[31:24]};
      2'd2: wdata = {lsu_req_i.wdata[15:0], lsu_req_i.wdata[31:16]};
      2'd3: wdata = {lsu_req_i.wdata[7:0],  lsu_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////
  // misalignment

  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i) begin
      if (lsu_req_i.dtype == dt_word && off != 2'd0) data_misaligned_o = 1'b1;
      if (lsu_req_i.dtype == dt_half && off == 2'd3) data_misaligned_o = 1'b1;
    end
  end

  // outputs
  assign obi_req_o.addr  = addr;
  assign obi_req_o.we    = lsu_req_i.we;
  assign obi_req_o.be    = be;
  assign obi_req_o.wdata = wdata;

  assign wb_ctrl_o.dtype    = lsu_req_i.dtype;
  assign wb_ctrl_o.offset   = off;
  assign wb_ctrl_o.sign_ext = lsu_req_i.sign_ext;
  assign wb_ctrl_o.we       = lsu_req_i.we;

endmodule

`default_nettype wire

//--- verilog/lsu_txn_ctrl.sv
// lsu transaction control: obi request, outstanding count and lock-step ex/wb ready
`default_nettype none

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,   // ex offers a request
  input  logic data_gnt_i,      // bus accepts address phase
  input  logic data_rvalid_i,   // bus response, in order
  output logic data_req_o,      // obi req
  output logic lsu_ready_ex_o,  // ex may advance
  output logic lsu_ready_wb_o,  // wb may advance
  output logic busy_o,          // transfers ongoing or pending
  output logic ctrl_update_o    // ex request accepted, wb control loads
);

  import lsu_pkg::*;

  cnt_t cnt_q;       // outstanding transactions
  cnt_t cnt_d;
  logic count_up;    // address phase granted
  logic count_down;  // response retired

  ////////////////////
  // bus request

  // no rvalid in this path, so req never waits on a response
  assign data_req_o = data_req_ex_i && (cnt_q < cnt_t'(depth_lp));

  assign count_up   = data_req_o && data_gnt_i;
  assign count_down = data_rvalid_i;

  ////////////////////
  // ready and busy

  assign lsu_ready_wb_o = (cnt_q == '0) || data_rvalid_i;

  // with one in flight, wb only frees up if its response comes now
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                    // nothing to do
    end else if (cnt_q == cnt_t'(0)) begin
      lsu_ready_ex_o = count_up;                // grant moves it to wb
    end else if (cnt_q == cnt_t'(1)) begin
      lsu_ready_ex_o = count_up && data_rvalid_i;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;           // full, wait for a retire
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  assign busy_o = (cnt_q != '0) || data_req_o;

  ////////////////////
  // outstanding counter

  always_comb begin
    cnt_d = cnt_q;                                    // up and down together cancel
    if (count_up && !count_down) cnt_d = cnt_q + 1'b1;
    if (!count_up && count_down) cnt_d = cnt_q - 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu_rdata_align.sv
// lsu output side: keeps wb control, aligns and extends load data, holds the last result
`default_nettype none

module lsu_rdata_align (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ctrl_update_i,  // ex request accepted
  input  logic                        data_rvalid_i,  // response this cycle
  input  lsu_pkg::wb_ctrl_t           wb_ctrl_i,      // control of the accepted request
  input  logic [lsu_pkg::xlen_lp-1:0] data_rdata_i,   // raw bus word
  output logic [lsu_pkg::xlen_lp-1:0] data_rdata_ex_o // aligned load result
);

  import lsu_pkg::*;

  wb_ctrl_t           wb_q;     // control of the access in wb
  logic [xlen_lp-1:0] rot;      // bus word shifted so the access starts at byte 0
  logic [15:0]        half;
  logic [xlen_lp-1:0] ext;      // extended result
  logic [xlen_lp-1:0] rdata_q;  // last load result
  logic               load_rsp; // rvalid belonging to a load

  // upper fill bit for the requested extension
  function automatic logic fill_bit(sign_ext_e se, logic msb);
    case (se)
      se_sign: fill_bit = msb;
      se_ones: fill_bit = 1'b1;
      default: fill_bit = 1'b0;  // zero extension
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q <= '0;
    end else if (ctrl_update_i) begin
      wb_q <= wb_ctrl_i;
    end
  end

  ////////////////////
  // alignment

  always_comb begin
    unique case (wb_q.offset)  // rotate right in whole bytes
      2'd0: rot = data_rdata_i;
      2'd1: rot = {data_rdata_i[7:0],  data_rdata_i[31:8]};
      2'd2: rot = {data_rdata_i[15:0], data_rdata_i[31:16]};
      2'd3: rot = {data_rdata_i[23:0], data_rdata_i[31:24]};
    endcase
  end

  // half at offset 3 only has its low byte in this word
  assign half = (wb_q.offset == 2'd3) ? {8'h00, rot[7:0]} : rot[15:0];

  always_comb begin
    unique case (wb_q.dtype)
      dt_word:              ext = rot;
      dt_half:              ext = {{16{fill_bit(wb_q.sign_ext, half[15])}}, half};
      dt_byte, dt_byte_alt: ext = {{24{fill_bit(wb_q.sign_ext, rot[7])}}, rot[7:0]};
    endcase
  end

  ////////////////////
  // result hold

  assign load_rsp = data_rvalid_i && !wb_q.we;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (load_rsp) begin
      rdata_q <= ext;
    end
  end

  assign data_rdata_ex_o = load_rsp ? ext : rdata_q;  // bypass in the response cycle

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
// load/store unit top, connects request formation, transaction control and load alignment
`default_nettype none

module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // ex stage
  input  logic                        data_req_ex_i,
  input  lsu_pkg::lsu_req_t           lsu_req_i,
  output logic [lsu_pkg::xlen_lp-1:0] data_rdata_ex_o,
  output logic                        data_misaligned_o,
  output logic                        lsu_ready_ex_o,
  output logic                        lsu_ready_wb_o,
  output logic                        busy_o,
  // obi data bus
  output logic                        data_req_o,
  output lsu_pkg::obi_req_t           data_obi_o,
  input  logic                        data_gnt_i,
  input  logic                        data_rvalid_i,
  input  logic [lsu_pkg::xlen_lp-1:0] data_rdata_i
);

  import lsu_pkg::*;

  wb_ctrl_t wb_ctrl;      // control of the request in ex
  logic     ctrl_update;  // ex -> wb handover

  lsu_req_gen u_req_gen (
    .lsu_req_i         (lsu_req_i),
    .data_req_ex_i     (data_req_ex_i),
    .obi_req_o         (data_obi_o),   // stable while ex holds the request
    .wb_ctrl_o         (wb_ctrl),
    .data_misaligned_o (data_misaligned_o)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o),
    .ctrl_update_o  (ctrl_update)
  );

  lsu_rdata_align u_rdata_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_update_i   (ctrl_update),
    .data_rvalid_i   (data_rvalid_i),
    .wb_ctrl_i       (wb_ctrl),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

//--- tb/lsu_assertions.sv
// obi protocol assertions for the lsu, attached to lsu_top by the bind at the end
`default_nettype none

module lsu_assertions (
  input logic              clk,
  input logic              rst_n,
  input logic              req_i,     // data_req_o of the lsu
  input lsu_pkg::obi_req_t obi_i,     // address phase
  input logic              gnt_i,
  input logic              rvalid_i
);

  import lsu_pkg::*;

  logic [2:0] outstanding_q;  // shadow count, one bit wider than cnt_t so overflow shows

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 3'(req_i && gnt_i) - 3'(rvalid_i);
    end
  end

  depth_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= 3'(depth_lp))
    else $error("outstanding count %0d above the limit", outstanding_q);

  rvalid_needs_txn: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> outstanding_q != '0)
    else $error("rvalid with no transaction outstanding");

  // address phase frozen until granted
  addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=> (req_i && $stable(obi_i)))
    else $error("request dropped or changed before its grant");

  addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !$isunknown(obi_i))
    else $error("unknown bits on the address phase");

endmodule

bind lsu_top lsu_assertions u_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .req_i    (data_req_o),
  .obi_i    (data_obi_o),
  .gnt_i    (data_gnt_i),
  .rvalid_i (data_rvalid_i)
);

`default_nettype wire

//--- tb/tb_lsu.sv
// testbench for lsu_top: replays accesses from the stim file against an in-order obi memory model
`default_nettype none

module tb_lsu;

  import lsu_pkg::*;

  // one access as read from the stim file
  typedef struct packed {
    logic        we;
    logic [1:0]  dtype;
    logic [1:0]  sext;
    logic [1:0]  roff;
    logic        incr;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] wdata;
    logic [31:0] rword;   // word the bus returns for this access
    logic [31:0] addr;    // expected bus address
    logic [3:0]  be;
    logic [31:0] bwdata;  // expected bus store data
    logic        mis;
    logic [31:0] res;     // expected result seen by ex in the response cycle
  } stim_t;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 data_req_ex_i = 1'b0;
  lsu_req_t             lsu_req_i = '0;
  logic                 data_gnt_i = 1'b0;
  logic                 data_rvalid_i = 1'b0;
  logic [xlen_lp-1:0]   data_rdata_i = '0;
  logic [xlen_lp-1:0]   data_rdata_ex_o;
  logic                 data_misaligned_o;
  logic                 lsu_ready_ex_o;
  logic                 lsu_ready_wb_o;
  logic                 busy_o;
  logic                 data_req_o;
  obi_req_t             data_obi_o;

  stim_t       stim_q[$];
  bit          stim_ready = 1'b0;  // file loaded, monitor and watchdog armed
  int          cur_idx = 0;        // access currently offered by ex
  int unsigned pend_idx[$];        // granted accesses waiting for rvalid, oldest first
  int unsigned pend_due[$];        // cycle from which each response may come
  int unsigned gnt_wait = 0;       // cycles left before the next grant
  int unsigned last_due = 0;
  int unsigned cyc = 0;
  int          rsp_cnt = 0;
  logic [31:0] last_res = '0;      // result ex should see between responses
  int          n_checks = 0;
  int          n_errors = 0;
  int          end_errors = 0;

  lsu_top dut (.*);

  always #20 clk = ~clk;

  task automatic compare(input string what, input int idx, input logic [31:0] exp,
                         input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("[ERROR] %s, access %0d: expected %h, actual %h", what, idx, exp, act);
    end
  endtask

  task automatic load_stimulus(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [14];
    stim_t       s;
    fd = $fopen("tb/lsu_stim.txt", "r");
    ok = (fd != 0);
    if (!ok) begin
      $display("cannot open tb/lsu_stim.txt, run from the project root");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
        if (n == 14) begin  // comment and blank lines give fewer fields
          s = '{we: f[0][0], dtype: f[1][1:0], sext: f[2][1:0], roff: f[3][1:0],
                incr: f[4][0], opa: f[5], opb: f[6], wdata: f[7], rword: f[8], addr: f[9],
                be: f[10][3:0], bwdata: f[11], mis: f[12][0], res: f[13]};
          stim_q.push_back(s);
        end
      end
      $fclose(fd);
      ok = (stim_q.size() != 0);
      if (!ok) $display("no accesses found in tb/lsu_stim.txt");
    end
  endtask

  // ex side, held until lsu_ready_ex_o
  task automatic drive_access(input int i);
    cur_idx              = i;
    data_req_ex_i        = 1'b1;
    lsu_req_i.we         = stim_q[i].we;
    lsu_req_i.dtype      = data_type_e'(stim_q[i].dtype);
    lsu_req_i.sign_ext   = sign_ext_e'(stim_q[i].sext);
    lsu_req_i.reg_offset = stim_q[i].roff;
    lsu_req_i.useincr    = stim_q[i].incr;
    lsu_req_i.operand_a  = stim_q[i].opa;
    lsu_req_i.operand_b  = stim_q[i].opb;
    lsu_req_i.wdata      = stim_q[i].wdata;
  endtask

  ////////////////////
  // bus model and checks, sampled at the rising edge

  always @(posedge clk) begin
    int unsigned due;
    int          idx;
    if (rst_n && stim_ready) begin
      compare("wb ready", cur_idx, 32'(pend_idx.size() == 0 || data_rvalid_i),
              32'(lsu_ready_wb_o));
      // req only while below the outstanding limit, busy while anything is pending
      compare("bus req", cur_idx, 32'(data_req_ex_i && pend_idx.size() < depth_lp),
              32'(data_req_o));
      compare("busy", cur_idx, 32'(data_req_ex_i || pend_idx.size() != 0), 32'(busy_o));
      if (data_req_ex_i) compare("misaligned", cur_idx, 32'(stim_q[cur_idx].mis),
                                 32'(data_misaligned_o));
      if (data_req_o && !data_gnt_i) begin
        assert (!lsu_ready_ex_o) else begin
          n_errors++;
          $display("ex ready went high while the grant of access %0d was withheld", cur_idx);
        end
      end
      if (data_rvalid_i) begin  // in-order response, retire the oldest
        idx = int'(pend_idx.pop_front());
        void'(pend_due.pop_front());
        compare("response order", rsp_cnt, rsp_cnt, idx);
        compare(stim_q[idx].we ? "held result" : "load result", idx, stim_q[idx].res,
                data_rdata_ex_o);
        last_res = stim_q[idx].res;
        rsp_cnt++;
      end else begin
        compare("held result", rsp_cnt, last_res, data_rdata_ex_o);
      end
      if (data_req_o && data_gnt_i) begin
        compare("address", cur_idx, stim_q[cur_idx].addr, data_obi_o.addr);
        compare("bus we", cur_idx, 32'(stim_q[cur_idx].we), 32'(data_obi_o.we));
        compare("byte enables", cur_idx, 32'(stim_q[cur_idx].be), 32'(data_obi_o.be));
        compare("bus store data", cur_idx, stim_q[cur_idx].bwdata, data_obi_o.wdata);
        due = cyc + $urandom_range(3, 1);  // response 1..3 cycles after grant
        if (due <= last_due) due = last_due + 1;  // keep order, one per cycle
        last_due = due;
        pend_idx.push_back(cur_idx);
        pend_due.push_back(due);
        assert (pend_idx.size() <= depth_lp) else begin
          n_errors++;
          $display("more than %0d accesses granted without a response", depth_lp);
        end
        gnt_wait = $urandom_range(2, 0);
      end else if (data_req_o && gnt_wait != 0) begin
        gnt_wait--;
      end
      cyc++;
    end
  end

  // bus outputs change on the falling edge
  always @(negedge clk) begin
    data_gnt_i = (gnt_wait == 0);
    if (pend_idx.size() != 0 && pend_due[0] <= cyc) begin
      data_rvalid_i = 1'b1;
      data_rdata_i  = stim_q[pend_idx[0]].rword;
    end else begin
      data_rvalid_i = 1'b0;
      data_rdata_i  = '0;
    end
  end

  ////////////////////
  // stimulus

  initial begin
    bit ok;
    void'($urandom(32'h50d9_5d2f));  // one seed for the whole run
    load_stimulus(ok);
    if (!ok) begin
      end_errors++;
    end else begin
      stim_ready = 1'b1;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < stim_q.size(); i++) begin
        @(negedge clk);
        drive_access(i);
        @(posedge clk);
        while (!lsu_ready_ex_o) @(posedge clk);  // accepted at this edge
      end
      @(negedge clk);
      data_req_ex_i = 1'b0;
      lsu_req_i     = '0;
      @(posedge clk);
      while (busy_o) @(posedge clk);  // drain the outstanding responses
      @(negedge clk);
      assert (rsp_cnt == stim_q.size()) else begin
        end_errors++;
        $display("busy dropped after %0d of %0d responses", rsp_cnt, stim_q.size());
      end
    end
    $display("checks %0d, errors %0d", n_checks, n_errors + end_errors);
    if (n_errors + end_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog, budget grows with the number of accesses
  initial begin
    wait (stim_ready);
    repeat (stim_q.size() * 12 + 100) @(posedge clk);
    $display("timeout, the DUT did not finish %0d accesses in time", stim_q.size());
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/lsu_stim.txt
// we dtype sext roff incr opa opb wdata rword, then expected addr be bus_wdata misaligned result
// result is the load result, for a store the value still held from the last load
1 0 0 0 1 00001000 00000010 11223344 00000000 00001010 f 11223344 0 00000000
1 0 0 0 0 00002001 00000000 11223344 00000000 00002001 e 22334411 1 00000000
1 0 0 0 1 00002000 00000002 11223344 00000000 00002002 c 33441122 1 00000000
1 0 0 0 0 00002003 00000000 11223344 00000000 00002003 8 44112233 1 00000000
1 1 0 0 0 00003000 00000000 0000abcd 00000000 00003000 3 0000abcd 0 00000000
1 1 0 0 0 00003001 00000000 0000abcd 00000000 00003001 6 00abcd00 0 00000000
1 1 0 2 1 00003000 00000002 abcd0000 00000000 00003002 c abcd0000 0 00000000
1 1 0 0 0 00003003 00000000 0000abcd 00000000 00003003 8 cd0000ab 1 00000000
1 3 0 3 0 00004001 00000000 ef000000 00000000 00004001 2 0000ef00 0 00000000
1 2 0 1 1 00004000 00000002 0000ef00 00000000 00004002 4 00ef0000 0 00000000
1 2 0 0 0 00004003 00000000 000000ef 00000000 00004003 8 ef000000 0 00000000
0 0 0 0 0 00005000 00000000 00000000 80f47fa5 00005000 f 00000000 0 80f47fa5
0 1 1 0 1 00005000 00000000 00000000 80f47fa5 00005000 3 00000000 0 00007fa5
0 1 1 0 0 00005002 00000000 00000000 80f47fa5 00005002 c 00000000 0 ffff80f4
0 1 2 0 0 00005001 00000000 00000000 80f47fa5 00005001 6 00000000 0 fffff47f
0 2 1 0 0 00005003 00000000 00000000 80f47fa5 00005003 8 00000000 0 ffffff80
0 3 0 0 1 00005000 00000001 00000000 80f47fa5 00005001 2 00000000 0 0000007f
0 1 1 0 0 00005003 00000000 00000000 80f47fa5 00005003 8 00000000 1 00000080
0 0 0 0 0 00005002 00000000 00000000 80f47fa5 00005002 c 00000000 1 7fa580f4
1 2 0 0 0 00004000 00000000 000000ef 00000000 00004000 1 000000ef 0 7fa580f4

//--- src.f
verilog/lsu_pkg.sv
verilog/lsu_req_gen.sv
verilog/lsu_txn_ctrl.sv
verilog/lsu_rdata_align.sv
verilog/lsu_top.sv
tb/lsu_assertions.sv
tb/tb_lsu.sv

//--- Makefile
TOP := tb_lsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

# the run fails unless the pass line shows up in the output
run: compile
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
